//--- verilog/gold_view_pkg.sv
// shared types, colors, point values and goal constants for the gold-mining view
// compile this package before any module that imports it
`default_nettype none

package gold_view_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;

	// 4-4-4 rgb, zero is transparent
	typedef logic [11:0] color_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
		logic     valid;
	} pixel_t;

	typedef enum logic [1:0] {
		kind_gold,
		kind_stone,
		kind_diamond
	} obj_kind_e;

	typedef struct packed {
		coord_x_t  x;
		coord_y_t  y;
		obj_kind_e kind;
		logic      visible;
	} obj_entry_t;

	typedef logic [11:0] score_t;
	typedef logic [4:0]  level_t;

	// 5 gold, 7 stone, 3 diamond
	localparam int MAX_OBJECTS = 15;
	typedef logic [3:0] obj_index_t;

	localparam color_t BG_COLOR      = 12'h631;
	localparam color_t GOLD_COLOR    = 12'hfc0;
	localparam color_t STONE_COLOR   = 12'h888;
	localparam color_t DIAMOND_COLOR = 12'h0ef;

	localparam score_t GOLD_VALUE    = 12'd10;
	localparam score_t STONE_VALUE   = 12'd2;
	localparam score_t DIAMOND_VALUE = 12'd50;

	// goal for a level is GOAL_BASE + GOAL_STEP * level
	localparam score_t GOAL_BASE = 12'd50;
	localparam score_t GOAL_STEP = 12'd100;

	function automatic color_t kind_color(obj_kind_e kind);
		case (kind)
			kind_gold:    return GOLD_COLOR;
			kind_stone:   return STONE_COLOR;
			kind_diamond: return DIAMOND_COLOR;
			default:      return '0;
		endcase
	endfunction

	function automatic score_t kind_value(obj_kind_e kind);
		case (kind)
			kind_gold:    return GOLD_VALUE;
			kind_stone:   return STONE_VALUE;
			kind_diamond: return DIAMOND_VALUE;
			default:      return '0;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- verilog/view_sequencer.sv
// frame FSM: background fill first, then one sprite per table index
// loops while playing and falls back to idle as soon as playing drops
`timescale 1ns/1ps
`default_nettype none

module view_sequencer (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       playing,
	output logic                      bg_start,
	input  wire                       bg_done,
	output logic                      sprite_start,
	input  wire                       sprite_done,
	output gold_view_pkg::obj_index_t obj_index
);
	import gold_view_pkg::*;

	localparam obj_index_t LAST_INDEX = obj_index_t'(MAX_OBJECTS - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_background,
		st_obj_start,
		st_obj_wait,
		st_next
	} state_e;

	state_e state;

	always_ff @(posedge clk) begin
		if (!resetn || !playing) begin
			state     <= st_idle;
			obj_index <= '0;
		end else begin
			case (state)
				// both launch a new frame
				st_idle, st_next: begin
					state     <= st_background;
					obj_index <= '0;
				end
				st_background: begin
					if (bg_done) begin
						state <= st_obj_start;
					end
				end
				st_obj_start: begin
					state <= st_obj_wait;
				end
				st_obj_wait: begin
					if (sprite_done) begin
						if (obj_index == LAST_INDEX) begin
							state <= st_next;
						end else begin
							obj_index <= obj_index + 1'b1;
							state     <= st_obj_start;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign bg_start     = playing && (state == st_idle || state == st_next);
	assign sprite_start = (state == st_obj_start);

endmodule

`default_nettype wire

//--- verilog/object_table.sv
// object registers with a write port, grab handling and an indexed read
// a valid grab hides the entry and reports the kind's points to round control
`timescale 1ns/1ps
`default_nettype none

module object_table (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       playing,
	input  wire                       obj_wr,
	input  gold_view_pkg::obj_index_t obj_wr_index,
	input  gold_view_pkg::obj_entry_t obj_wr_entry,
	input  wire                       grab,
	input  gold_view_pkg::obj_index_t grab_index,
	input  gold_view_pkg::obj_index_t read_index,
	output gold_view_pkg::obj_entry_t read_entry,
	output logic                      score_add,
	output gold_view_pkg::score_t     add_value
);
	import gold_view_pkg::*;

	obj_entry_t entries [MAX_OBJECTS];
	obj_entry_t grab_entry;
	logic       grab_hit;

	// index 15 lies past the table and reads as an invisible entry
	assign read_entry = (read_index < obj_index_t'(MAX_OBJECTS)) ? entries[read_index] : '0;
	assign grab_entry = (grab_index < obj_index_t'(MAX_OBJECTS)) ? entries[grab_index] : '0;

	assign grab_hit  = grab && playing && grab_entry.visible;
	assign score_add = grab_hit;
	assign add_value = kind_value(grab_entry.kind);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < MAX_OBJECTS; i++) begin
				entries[i].visible <= 1'b0;
			end
		end else begin
			if (grab_hit) begin
				entries[grab_index].visible <= 1'b0;
			end
			// a write to the same entry overrides the grab
			if (obj_wr && obj_wr_index < obj_index_t'(MAX_OBJECTS)) begin
				entries[obj_wr_index] <= obj_wr_entry;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/background_fill.sv
// raster counter that paints the whole screen in the background color
// one pixel per cycle after start, done comes with the last pixel
`timescale 1ns/1ps
`default_nettype none

module background_fill #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
) (
	input  wire                   clk,
	input  wire                   resetn,
	input  wire                   start,
	output gold_view_pkg::pixel_t pixel,
	output logic                  done
);
	import gold_view_pkg::*;

	localparam coord_x_t X_LAST = coord_x_t'(SCREEN_W - 1);
	localparam coord_y_t Y_LAST = coord_y_t'(SCREEN_H - 1);

	coord_x_t x;
	coord_y_t y;
	logic     active;
	logic     row_end;

	assign row_end = (x == X_LAST);
	assign done    = active && row_end && (y == Y_LAST);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			x      <= '0;
			y      <= '0;
		end else if (start) begin
			active <= 1'b1;
			x      <= '0;
			y      <= '0;
		end else if (active) begin
			if (done) begin
				active <= 1'b0;
			end
			x <= row_end ? '0 : x + 1'b1;
			if (row_end) begin
				y <= y + 1'b1;
			end
		end
	end

	assign pixel = '{x: x, y: y, color: BG_COLOR, valid: active};

endmodule

`default_nettype wire

//--- verilog/sprite_draw.sv
// draws one object as a square sprite in its kind's color
// corners come out with color zero so the output stage skips them
`timescale 1ns/1ps
`default_nettype none

module sprite_draw #(
	parameter int SPRITE_SIZE = 16
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       start,
	input  gold_view_pkg::obj_entry_t entry,
	output gold_view_pkg::pixel_t     pixel,
	output logic                      done
);
	import gold_view_pkg::*;

	localparam int OFS_W = (SPRITE_SIZE > 1) ? $clog2(SPRITE_SIZE) : 1;
	localparam logic [OFS_W-1:0] OFS_LAST = OFS_W'(SPRITE_SIZE - 1);

	obj_entry_t       ent;
	logic [OFS_W-1:0] ofs_x;
	logic [OFS_W-1:0] ofs_y;
	logic             active;
	logic             last;
	logic             edge_x;
	logic             edge_y;

	assign last   = (ofs_x == OFS_LAST) && (ofs_y == OFS_LAST);
	// an invisible entry spends a single cycle
	assign done   = active && (last || !ent.visible);
	assign edge_x = (ofs_x == '0) || (ofs_x == OFS_LAST);
	assign edge_y = (ofs_y == '0) || (ofs_y == OFS_LAST);

	always_ff @(posedge clk) begin
		if (start) begin
			ent <= entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			ofs_x  <= '0;
			ofs_y  <= '0;
		end else if (start) begin
			active <= 1'b1;
			ofs_x  <= '0;
			ofs_y  <= '0;
		end else if (active) begin
			if (done) begin
				active <= 1'b0;
			end
			ofs_x <= (ofs_x == OFS_LAST) ? '0 : ofs_x + 1'b1;
			if (ofs_x == OFS_LAST) begin
				ofs_y <= ofs_y + 1'b1;
			end
		end
	end

	assign pixel.x     = ent.x + coord_x_t'(ofs_x);
	assign pixel.y     = ent.y + coord_y_t'(ofs_y);
	assign pixel.color = (edge_x && edge_y) ? '0 : kind_color(ent.kind);
	assign pixel.valid = active && ent.visible;

endmodule

`default_nettype wire

//--- verilog/pixel_out_stage.sv
// output register for the pixel stream
// background wins over sprite, transparent pixels are not written
`timescale 1ns/1ps
`default_nettype none

module pixel_out_stage (
	input  wire                   clk,
	input  wire                   resetn,
	input  gold_view_pkg::pixel_t bg_pixel,
	input  gold_view_pkg::pixel_t sprite_pixel,
	output gold_view_pkg::pixel_t pixel_out
);
	import gold_view_pkg::*;

	pixel_t sel;

	assign sel = bg_pixel.valid ? bg_pixel : sprite_pixel;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pixel_out.valid <= 1'b0;
		end else begin
			pixel_out.valid <= sel.valid && (sel.color != '0);
		end
		pixel_out.x     <= sel.x;
		pixel_out.y     <= sel.y;
		pixel_out.color <= sel.color;
	end

endmodule

`default_nettype wire

//--- verilog/round_control.sv
// round timer, score, level and goal check
// at expiry the player moves up a level or the game ends
`timescale 1ns/1ps
`default_nettype none

module round_control #(
	parameter int ROUND_TIME       = 60,
	parameter int TICKS_PER_SECOND = 50_000_000
) (
	input  wire                   clk,
	input  wire                   resetn,
	input  wire                   go,
	input  wire                   score_add,
	input  gold_view_pkg::score_t add_value,
	output logic                  playing,
	output logic                  game_over,
	output gold_view_pkg::score_t score,
	output gold_view_pkg::level_t level,
	output logic [7:0]            time_remaining
);
	import gold_view_pkg::*;

	localparam int PRE_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_SECOND - 1);

	logic [PRE_W-1:0] prescale;
	logic             tick;
	score_t           goal;
	score_t           score_next;

	assign tick       = playing && (prescale == PRE_LAST);
	assign goal       = GOAL_BASE + GOAL_STEP * score_t'(level);
	// a grab on the expiry cycle still counts toward the goal
	assign score_next = score_add ? score + add_value : score;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			playing        <= 1'b0;
			game_over      <= 1'b0;
			score          <= '0;
			level          <= '0;
			time_remaining <= '0;
			prescale       <= '0;
		end else if (go && !playing) begin
			playing        <= 1'b1;
			game_over      <= 1'b0;
			score          <= '0;
			level          <= '0;
			time_remaining <= 8'(ROUND_TIME);
			prescale       <= '0;
		end else if (playing) begin
			prescale <= tick ? '0 : prescale + 1'b1;
			score    <= score_next;
			if (tick && time_remaining != '0) begin
				if (time_remaining != 8'd1) begin
					time_remaining <= time_remaining - 1'b1;
				end else if (score_next >= goal) begin
					// next level
					level          <= level + 1'b1;
					score          <= '0;
					time_remaining <= 8'(ROUND_TIME);
				end else begin
					time_remaining <= '0;
					playing        <= 1'b0;
					game_over      <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/gold_view.sv
// top level of the gold-mining view and round controller
// streams frame pixels on pixel_out and reports score, level and time
`timescale 1ns/1ps
`default_nettype none

module gold_view #(
	parameter int SCREEN_W         = 320,
	parameter int SCREEN_H         = 240,
	parameter int SPRITE_SIZE      = 16,
	parameter int ROUND_TIME       = 60,
	parameter int TICKS_PER_SECOND = 50_000_000
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       go,
	input  wire                       obj_wr,
	input  gold_view_pkg::obj_index_t obj_wr_index,
	input  gold_view_pkg::obj_entry_t obj_wr_entry,
	input  wire                       grab,
	input  gold_view_pkg::obj_index_t grab_index,
	output gold_view_pkg::pixel_t     pixel_out,
	output gold_view_pkg::score_t     score,
	output gold_view_pkg::level_t     level,
	output logic [7:0]                time_remaining,
	output logic                      playing,
	output logic                      game_over
);
	import gold_view_pkg::*;

	pixel_t     bg_pixel;
	pixel_t     sprite_pixel;
	obj_entry_t cur_entry;
	obj_index_t obj_index;
	score_t     add_value;
	logic       bg_start;
	logic       bg_done;
	logic       sprite_start;
	logic       sprite_done;
	logic       score_add;
	logic       run_resetn;

	// drawing path is held clear whenever no round is running
	assign run_resetn = resetn & playing;

	view_sequencer u_sequencer (
		.clk          (clk),
		.resetn       (resetn),
		.playing      (playing),
		.bg_start     (bg_start),
		.bg_done      (bg_done),
		.sprite_start (sprite_start),
		.sprite_done  (sprite_done),
		.obj_index    (obj_index)
	);

	object_table u_table (
		.clk          (clk),
		.resetn       (resetn),
		.playing      (playing),
		.obj_wr       (obj_wr),
		.obj_wr_index (obj_wr_index),
		.obj_wr_entry (obj_wr_entry),
		.grab         (grab),
		.grab_index   (grab_index),
		.read_index   (obj_index),
		.read_entry   (cur_entry),
		.score_add    (score_add),
		.add_value    (add_value)
	);

	background_fill #(
		.SCREEN_W (SCREEN_W),
		.SCREEN_H (SCREEN_H)
	) u_background (
		.clk    (clk),
		.resetn (run_resetn),
		.start  (bg_start),
		.pixel  (bg_pixel),
		.done   (bg_done)
	);

	sprite_draw #(
		.SPRITE_SIZE (SPRITE_SIZE)
	) u_sprite (
		.clk    (clk),
		.resetn (run_resetn),
		.start  (sprite_start),
		.entry  (cur_entry),
		.pixel  (sprite_pixel),
		.done   (sprite_done)
	);

	pixel_out_stage u_out_stage (
		.clk          (clk),
		.resetn       (run_resetn),
		.bg_pixel     (bg_pixel),
		.sprite_pixel (sprite_pixel),
		.pixel_out    (pixel_out)
	);

	round_control #(
		.ROUND_TIME       (ROUND_TIME),
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) u_round (
		.clk            (clk),
		.resetn         (resetn),
		.go             (go),
		.score_add      (score_add),
		.add_value      (add_value),
		.playing        (playing),
		.game_over      (game_over),
		.score          (score),
		.level          (level),
		.time_remaining (time_remaining)
	);

endmodule

`default_nettype wire

//--- verif/gold_view_checker.sv
// concurrent checks on the pixel stream and the round flags of gold_view
// attached to every gold_view instance by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module gold_view_checker #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
) (
	input wire                   clk,
	input wire                   resetn,
	input gold_view_pkg::pixel_t pixel_out,
	input wire                   playing,
	input wire                   game_over
);

	opaque_pixel: assert property (@(posedge clk) disable iff (!resetn)
		pixel_out.valid |-> pixel_out.color != '0)
		else $error("valid pixel with transparent color");

	on_screen: assert property (@(posedge clk) disable iff (!resetn)
		pixel_out.valid |-> (pixel_out.x < SCREEN_W) && (pixel_out.y < SCREEN_H))
		else $error("pixel written outside the screen");

	flags_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		!(playing && game_over))
		else $error("playing and game_over set together");

	// output register clears one edge after playing drops
	quiet_when_stopped: assert property (@(posedge clk) disable iff (!resetn)
		!playing |=> !pixel_out.valid)
		else $error("pixel written while no round is running");

endmodule

bind gold_view gold_view_checker #(
	.SCREEN_W (SCREEN_W),
	.SCREEN_H (SCREEN_H)
) u_checker (
	.clk       (clk),
	.resetn    (resetn),
	.pixel_out (pixel_out),
	.playing   (playing),
	.game_over (game_over)
);

`default_nettype wire

//--- verif/gold_view_tb.sv
// directed testbench for gold_view covering reset, frames, sprites, grabs, level up and game over
// runs as top module gold_view_tb with the checker bound to the DUT from its own file
`timescale 1ns/1ps
`default_nettype none

module gold_view_tb;
	import gold_view_pkg::*;

	localparam int SCREEN_W         = 16;
	localparam int SCREEN_H         = 12;
	localparam int SPRITE_SIZE      = 4;
	localparam int ROUND_TIME       = 3;
	localparam int TICKS_PER_SECOND = 600;
	// three rounds of 1800 cycles plus reset and frame waits stay far below this
	localparam int MAX_CYCLES       = 20000;

	logic       clk;
	logic       resetn;
	logic       go;
	logic       obj_wr;
	obj_index_t obj_wr_index;
	obj_entry_t obj_wr_entry;
	logic       grab;
	obj_index_t grab_index;
	pixel_t     pixel_out;
	score_t     score;
	level_t     level;
	logic [7:0] time_remaining;
	logic       playing;
	logic       game_over;

	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int          round_start;
	logic [31:0] lfsr;
	logic        round_on;
	score_t      exp_score;
	level_t      exp_level;
	obj_entry_t  model [16];
	pixel_t      writes [$];
	int          marks [$];
	pixel_t      expected [$];

	gold_view #(
		.SCREEN_W         (SCREEN_W),
		.SCREEN_H         (SCREEN_H),
		.SPRITE_SIZE      (SPRITE_SIZE),
		.ROUND_TIME       (ROUND_TIME),
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) u_dut (
		.clk            (clk),
		.resetn         (resetn),
		.go             (go),
		.obj_wr         (obj_wr),
		.obj_wr_index   (obj_wr_index),
		.obj_wr_entry   (obj_wr_entry),
		.grab           (grab),
		.grab_index     (grab_index),
		.pixel_out      (pixel_out),
		.score          (score),
		.level          (level),
		.time_remaining (time_remaining),
		.playing        (playing),
		.game_over      (game_over)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// a background pixel at the origin marks the start of a frame
	always @(posedge clk) begin
		if (pixel_out.valid) begin
			if (pixel_out.x == '0 && pixel_out.y == '0 && pixel_out.color == BG_COLOR) begin
				marks.push_back(writes.size());
			end
			writes.push_back(pixel_out);
		end
	end

	initial begin
		wait (cycle_count >= MAX_CYCLES);
		$display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
			r    = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic color_t sprite_color(input obj_kind_e k);
		if (k == kind_gold) return GOLD_COLOR;
		if (k == kind_stone) return STONE_COLOR;
		return DIAMOND_COLOR;
	endfunction

	function automatic score_t grab_points(input obj_kind_e k);
		if (k == kind_gold) return 12'd10;
		if (k == kind_stone) return 12'd2;
		return 12'd50;
	endfunction

	function automatic score_t goal_for(input level_t lvl);
		return score_t'(50 + 100 * int'(lvl));
	endfunction

	function automatic obj_entry_t random_entry();
		obj_entry_t e;
		e.x       = coord_x_t'(rand_bits(4) % (SCREEN_W - SPRITE_SIZE + 1));
		e.y       = coord_y_t'(rand_bits(4) % (SCREEN_H - SPRITE_SIZE + 1));
		e.kind    = obj_kind_e'(rand_bits(2) % 3);
		e.visible = (rand_bits(1) != 0);
		return e;
	endfunction

	// background raster followed by 12 pixels per visible object in table order
	function automatic void build_expected();
		pixel_t p;
		logic   corner;
		expected.delete();
		p.valid = 1'b1;
		for (int y = 0; y < SCREEN_H; y++) begin
			for (int x = 0; x < SCREEN_W; x++) begin
				p.x     = coord_x_t'(x);
				p.y     = coord_y_t'(y);
				p.color = BG_COLOR;
				expected.push_back(p);
			end
		end
		for (int i = 0; i < MAX_OBJECTS; i++) begin
			if (model[i].visible) begin
				for (int oy = 0; oy < SPRITE_SIZE; oy++) begin
					for (int ox = 0; ox < SPRITE_SIZE; ox++) begin
						corner = (ox == 0 || ox == SPRITE_SIZE - 1) &&
							(oy == 0 || oy == SPRITE_SIZE - 1);
						p.x     = model[i].x + coord_x_t'(ox);
						p.y     = model[i].y + coord_y_t'(oy);
						p.color = sprite_color(model[i].kind);
						if (!corner) begin
							expected.push_back(p);
						end
					end
				end
			end
		end
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("FAILED %s: %s expected %0h actual %0h", test, what, exp, act);
		end
	endtask

	task automatic check_true(input string test, input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR in %s: %s", test, msg);
		end
	endtask

	task automatic check_idle(input string test);
		check_value(test, "pixel valid", 0, pixel_out.valid);
		check_value(test, "playing", 0, playing);
		check_value(test, "game_over", 0, game_over);
		check_value(test, "score", 0, score);
		check_value(test, "level", 0, level);
		check_value(test, "time_remaining", 0, time_remaining);
	endtask

	task automatic clear_capture();
		writes.delete();
		marks.delete();
	endtask

	task automatic pulse_go();
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		round_on    = 1'b1;
		exp_score   = '0;
		exp_level   = '0;
		round_start = cycle_count;
	endtask

	task automatic write_entry(input obj_index_t idx, input obj_entry_t e);
		obj_wr       = 1'b1;
		obj_wr_index = idx;
		obj_wr_entry = e;
		@(negedge clk);
		obj_wr     = 1'b0;
		model[idx] = e;
	endtask

	task automatic do_grab(input string test, input obj_index_t idx);
		grab       = 1'b1;
		grab_index = idx;
		if (round_on && model[idx].visible) begin
			exp_score         = exp_score + grab_points(model[idx].kind);
			model[idx].visible = 1'b0;
		end
		@(negedge clk);
		grab = 1'b0;
		check_value(test, $sformatf("score after grab of %0d", idx), exp_score, score);
	endtask

	// compares one whole frame from its start mark to the next one
	task automatic check_next_frame(input string test);
		int first;
		int len;
		while (marks.size() < 2) @(negedge clk);
		first = marks[0];
		len   = marks[1] - marks[0];
		void'(marks.pop_front());
		build_expected();
		check_value(test, "frame write count", expected.size(), len);
		if (len == expected.size()) begin
			for (int i = 0; i < len; i++) begin
				check_value(test, $sformatf("write %0d x,y,color", i),
					{expected[i].x, expected[i].y, expected[i].color},
					{writes[first + i].x, writes[first + i].y, writes[first + i].color});
			end
		end
	endtask

	task automatic reset_test();
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			check_idle("reset");
		end
		resetn = 1'b1;
		repeat (8) begin
			@(negedge clk);
			check_idle("reset");
		end
		check_value("reset", "pixel writes before go", 0, writes.size());
	endtask

	task automatic background_test();
		clear_capture();
		pulse_go();
		check_value("background", "playing", 1, playing);
		check_value("background", "time_remaining", ROUND_TIME, time_remaining);
		while (writes.size() < SCREEN_W * SCREEN_H) @(negedge clk);
		for (int i = 0; i < SCREEN_W * SCREEN_H; i++) begin
			check_value("background", $sformatf("write %0d x,y,color", i),
				{coord_x_t'(i % SCREEN_W), coord_y_t'(i / SCREEN_W), BG_COLOR},
				{writes[i].x, writes[i].y, writes[i].color});
		end
	endtask

	task automatic sprite_test();
		obj_entry_t e;
		for (int i = 0; i < MAX_OBJECTS; i++) begin
			e = random_entry();
			// at least one shown and one hidden object
			if (i == 0) e.visible = 1'b1;
			if (i == MAX_OBJECTS - 1) e.visible = 1'b0;
			write_entry(obj_index_t'(i), e);
		end
		clear_capture();
		check_next_frame("sprites");
		check_next_frame("sprites");
	endtask

	task automatic grab_test();
		obj_index_t idx;
		for (int k = 0; k < 6; k++) begin
			idx = obj_index_t'(rand_bits(4));
			do_grab("grab", idx);
			// repeat finds the entry hidden already
			do_grab("grab", idx);
		end
		do_grab("grab", obj_index_t'(0));
		do_grab("grab", obj_index_t'(MAX_OBJECTS - 1));
		do_grab("grab", obj_index_t'(15));
		clear_capture();
		check_next_frame("grab");
	endtask

	task automatic level_up_test();
		obj_entry_t e;
		if (exp_score < goal_for(exp_level)) begin
			e         = random_entry();
			e.kind    = kind_diamond;
			e.visible = 1'b1;
			write_entry(obj_index_t'(0), e);
			do_grab("level up", obj_index_t'(0));
		end
		check_true("level up", score >= goal_for(exp_level), "score still below the goal");
		while (time_remaining != 8'd1) @(negedge clk);
		while (time_remaining == 8'd1) @(negedge clk);
		check_value("level up", "cycles in round", ROUND_TIME * TICKS_PER_SECOND,
			cycle_count - round_start);
		round_start = cycle_count;
		exp_level = exp_level + 1'b1;
		exp_score = '0;
		check_value("level up", "level", exp_level, level);
		check_value("level up", "score", exp_score, score);
		check_value("level up", "time_remaining", ROUND_TIME, time_remaining);
		check_value("level up", "playing", 1, playing);
		check_value("level up", "game_over", 0, game_over);
	endtask

	task automatic game_over_test();
		obj_index_t idx;
		check_true("game over", score < goal_for(exp_level), "score already meets the goal");
		while (playing) @(negedge clk);
		check_value("game over", "cycles in round", ROUND_TIME * TICKS_PER_SECOND,
			cycle_count - round_start);
		round_on = 1'b0;
		check_value("game over", "game_over", 1, game_over);
		check_value("game over", "level", exp_level, level);
		check_value("game over", "time_remaining", 0, time_remaining);
		repeat (2) @(negedge clk);
		clear_capture();
		repeat (100) @(negedge clk);
		check_value("game over", "pixel writes after end", 0, writes.size());
		// grab while stopped must not score
		idx = '0;
		for (int i = 0; i < MAX_OBJECTS; i++) begin
			if (model[i].visible) idx = obj_index_t'(i);
		end
		do_grab("game over", idx);
		pulse_go();
		check_value("game over", "playing after go", 1, playing);
		check_value("game over", "game_over after go", 0, game_over);
		check_value("game over", "score after go", 0, score);
		check_value("game over", "level after go", 0, level);
		check_value("game over", "time_remaining after go", ROUND_TIME, time_remaining);
	endtask

	initial begin
		resetn       = 1'b0;
		go           = 1'b0;
		obj_wr       = 1'b0;
		obj_wr_index = '0;
		obj_wr_entry = '0;
		grab         = 1'b0;
		grab_index   = '0;
		lfsr         = 32'he079_f8ce;
		round_on     = 1'b0;
		round_start  = 0;
		exp_score    = '0;
		exp_level    = '0;
		for (int i = 0; i < 16; i++) begin
			model[i] = '0;
		end
		reset_test();
		background_test();
		sprite_test();
		game_over_test();
		grab_test();
		level_up_test();
		game_over_test();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/gold_view_pkg.sv
verilog/view_sequencer.sv
verilog/object_table.sv
verilog/background_fill.sv
verilog/sprite_draw.sv
verilog/pixel_out_stage.sv
verilog/round_control.sv
verilog/gold_view.sv
verif/gold_view_checker.sv
verif/gold_view_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = gold_view_tb
FLIST     = flist.f
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
